// ==== source/uart_macros.svh ====
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// system clock and line rate
`define UART_CLK_HZ 50000000
`define UART_BAUD 115200

// default divider, 434 at 50 MHz
`define UART_CLKS_PER_BIT (`UART_CLK_HZ / `UART_BAUD)

// read response window in bit periods
`define UART_RESP_TIMEOUT_BITS 40

`endif

// ==== source/uart_frame_pkg.sv ====
package uart_frame_pkg;

  // one data byte on the line
  typedef logic [7:0] uart_byte_t;

  // position within an 11-bit frame
  typedef logic [3:0] bit_idx_t;

  // clocks within one bit period
  typedef logic [15:0] baud_cnt_t;

  // received byte with its frame checks
  typedef struct packed {
    uart_byte_t data;
    logic       parity_ok;
    logic       stop_ok;
  } rx_byte_s;

endpackage

// ==== source/cmd_pkg.sv ====
package cmd_pkg;

  // raw command word from the host
  typedef logic [15:0] cmd_word_t;

  // field view, bit 15 is the read flag
  typedef struct packed {
    logic                     rd;
    logic [6:0]               addr_hi;
    uart_frame_pkg::uart_byte_t addr_lo;
  } cmd_fields_s;

  // result of a read command
  typedef struct packed {
    logic                     timeout;
    logic                     parity_err;
    uart_frame_pkg::uart_byte_t data;
  } read_result_s;

  typedef enum logic [2:0] {
    IDLE,
    SEND_HI,
    SEND_LO,
    WAIT_RESP,
    DONE
  } seq_state_e;

endpackage

// ==== source/uart_tx_frame.sv ====
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_tx_frame #(
  parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       tx_start,
  input  uart_frame_pkg::uart_byte_t tx_byte,
  output logic                       tx_busy,
  output logic                       tx
);

  import uart_frame_pkg::*;

  localparam baud_cnt_t last_cnt = baud_cnt_t'(clks_per_bit - 1);
  localparam bit_idx_t  last_bit = bit_idx_t'(10);

  logic [10:0] frame_sh;
  baud_cnt_t   baud_cnt;
  bit_idx_t    bit_idx;

  // line always shows the lsb of the frame register
  assign tx = frame_sh[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_sh <= '1;
      tx_busy  <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else if (tx_start && !tx_busy) begin
      // stop, odd parity, data lsb first, start
      frame_sh <= {1'b1, ~^tx_byte, tx_byte, 1'b0};
      tx_busy  <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else if (tx_busy) begin
      if (baud_cnt == last_cnt) begin
        baud_cnt <= '0;
        frame_sh <= {1'b1, frame_sh[10:1]};
        if (bit_idx == last_bit) begin
          tx_busy <= 1'b0;
          bit_idx <= '0;
        end else begin
          bit_idx <= bit_idx + 1'b1;
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // idle line stays at mark
  a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    !tx_busy |-> tx)
    else $error("tx low while idle");

  // sequencer must wait for the frame to finish
  a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    tx_busy |-> !tx_start)
    else $error("tx_start while tx_busy");

endmodule

// ==== source/uart_rx_frame.sv ====
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_rx_frame #(
  parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     rx,
  output logic                     rx_valid,
  output uart_frame_pkg::rx_byte_s rx_byte
);

  import uart_frame_pkg::*;

  localparam baud_cnt_t last_cnt = baud_cnt_t'(clks_per_bit - 1);
  localparam baud_cnt_t mid_cnt  = baud_cnt_t'(clks_per_bit / 2);
  localparam bit_idx_t  stop_bit = bit_idx_t'(10);

  logic [2:0] rx_dly;
  logic       rx_s;
  logic       rx_fall;
  logic       active;
  logic       sample;
  baud_cnt_t  baud_cnt;
  bit_idx_t   bit_idx;
  // data bits plus parity, parity ends up on top
  logic [8:0] data_sh;

  // two sync flops, third stage for the edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_dly <= 3'b111;
    end else begin
      rx_dly <= {rx_dly[1:0], rx};
    end
  end

  assign rx_s    = rx_dly[1];
  assign rx_fall = rx_dly[2] && !rx_dly[1];
  assign sample  = active && (baud_cnt == mid_cnt);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!active) begin
        if (rx_fall) begin
          active   <= 1'b1;
          baud_cnt <= '0;
          bit_idx  <= '0;
        end
      end else begin
        baud_cnt <= (baud_cnt == last_cnt) ? '0 : baud_cnt + 1'b1;
        if (sample) begin
          bit_idx <= bit_idx + 1'b1;
          // start bit gone high again at mid-bit means a glitch
          if (bit_idx == '0 && rx_s) begin
            active <= 1'b0;
          end
          if (bit_idx == stop_bit) begin
            active   <= 1'b0;
            rx_valid <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample && bit_idx != '0 && bit_idx != stop_bit) begin
      data_sh <= {rx_s, data_sh[8:1]};
    end
    if (sample && bit_idx == stop_bit) begin
      rx_byte.data      <= data_sh[7:0];
      rx_byte.parity_ok <= ^data_sh;
      rx_byte.stop_ok   <= rx_s;
    end
  end

  a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    rx_valid |=> !rx_valid)
    else $error("rx_valid held for two cycles");

endmodule

// ==== source/cmd_sequencer.sv ====
`timescale 1ns/1ps
`include "uart_macros.svh"

module cmd_sequencer #(
  parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  cmd_pkg::cmd_word_t         cmd_in,
  input  logic                       cmd_vld,
  output logic                       cmd_rdy,
  output logic                       tx_start,
  output uart_frame_pkg::uart_byte_t tx_byte,
  input  logic                       tx_busy,
  input  logic                       rx_valid,
  input  uart_frame_pkg::rx_byte_s   rx_byte,
  output logic                       read_rdy,
  output cmd_pkg::read_result_s      read_data
);

  import cmd_pkg::*;

  localparam int unsigned resp_cycles = `UART_RESP_TIMEOUT_BITS * clks_per_bit;
  localparam int to_w = $clog2(resp_cycles);

  seq_state_e      state;
  cmd_fields_s     cmd_q;
  logic            issued;
  logic            frame_done;
  logic            accept;
  logic [to_w-1:0] to_cnt;

  assign accept     = cmd_vld && cmd_rdy;
  // busy already high the cycle after the strobe
  assign frame_done = issued && !tx_busy;
  assign tx_start   = (state == SEND_HI || state == SEND_LO) && !issued && !tx_busy;
  assign tx_byte    = (state == SEND_HI) ? {cmd_q.rd, cmd_q.addr_hi} : cmd_q.addr_lo;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      cmd_rdy  <= 1'b1;
      read_rdy <= 1'b0;
      issued   <= 1'b0;
      to_cnt   <= '0;
    end else begin
      read_rdy <= 1'b0;
      if (tx_start) begin
        issued <= 1'b1;
      end
      case (state)
        IDLE, DONE: begin
          state <= IDLE;
          if (accept) begin
            cmd_rdy <= 1'b0;
            state   <= SEND_HI;
          end
        end
        SEND_HI: begin
          if (frame_done) begin
            issued <= 1'b0;
            state  <= SEND_LO;
          end
        end
        SEND_LO: begin
          if (frame_done) begin
            issued <= 1'b0;
            to_cnt <= '0;
            if (cmd_q.rd) begin
              state <= WAIT_RESP;
            end else begin
              cmd_rdy <= 1'b1;
              state   <= IDLE;
            end
          end
        end
        WAIT_RESP: begin
          to_cnt <= to_cnt + 1'b1;
          if (rx_valid || to_cnt == to_w'(resp_cycles - 1)) begin
            read_rdy <= 1'b1;
            cmd_rdy  <= 1'b1;
            state    <= DONE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // command and result payload
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
    if (state == WAIT_RESP) begin
      if (rx_valid) begin
        read_data.timeout    <= 1'b0;
        read_data.parity_err <= !(rx_byte.parity_ok && rx_byte.stop_ok);
        read_data.data       <= rx_byte.data;
      end else begin
        // no byte arrived
        read_data <= '{timeout: 1'b1, parity_err: 1'b0, data: '0};
      end
    end
  end

  a_rdy_vs_busy: assert property (@(posedge clk) disable iff (!rst_n)
    !(cmd_rdy && tx_busy))
    else $error("cmd_rdy high during a frame");

  a_read_rdy_src: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(read_rdy) |-> $past(state == WAIT_RESP))
    else $error("read_rdy outside a read");

endmodule

// ==== source/uart_cmd_bridge.sv ====
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_cmd_bridge #(
  parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cmd_pkg::cmd_word_t    cmd_in,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  input  logic                  rx,
  output logic                  tx,
  output logic                  read_rdy,
  output cmd_pkg::read_result_s read_data
);

  import uart_frame_pkg::*;

  logic       tx_start;
  logic       tx_busy;
  uart_byte_t tx_byte;
  logic       rx_valid;
  rx_byte_s   rx_byte;

  cmd_sequencer #(
    .clks_per_bit(clks_per_bit)
  ) i_cmd_sequencer (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte),
    .read_rdy (read_rdy),
    .read_data(read_data)
  );

  uart_tx_frame #(
    .clks_per_bit(clks_per_bit)
  ) i_uart_tx_frame (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_start(tx_start),
    .tx_byte (tx_byte),
    .tx_busy (tx_busy),
    .tx      (tx)
  );

  uart_rx_frame #(
    .clks_per_bit(clks_per_bit)
  ) i_uart_rx_frame (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_valid(rx_valid),
    .rx_byte (rx_byte)
  );

endmodule

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real period_ns = 10.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2.0) clk = ~clk;
  end

endmodule

// ==== testbench/tb_serial_peer.sv ====
`timescale 1ns/1ps

module tb_serial_peer #(
  parameter int clks_per_bit = 16
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     tx,
  output logic                     rx,
  output logic                     frame_vld,
  output uart_frame_pkg::rx_byte_s frame
);

  import uart_frame_pkg::*;

  uart_byte_t hi_byte;
  logic       second;
  int         req_cnt;
  int         ans_cnt;
  uart_byte_t ans_byte;
  logic       ans_bad_par;

  // decode frames from the DUT, sampled on the falling edge
  initial begin : decoder
    uart_byte_t d;
    logic       par;
    frame_vld = 1'b0;
    frame     = '0;
    second    = 1'b0;
    req_cnt   = 0;
    forever begin
      @(negedge clk);
      frame_vld = 1'b0;
      if (rst_n && !tx) begin
        repeat (clks_per_bit / 2) @(negedge clk);
        // start bit still low at mid-bit
        if (!tx) begin
          for (int i = 0; i < 8; i++) begin
            repeat (clks_per_bit) @(negedge clk);
            d[i] = tx;
          end
          repeat (clks_per_bit) @(negedge clk);
          par = tx;
          repeat (clks_per_bit) @(negedge clk);
          frame.data      = d;
          frame.parity_ok = ^{d, par};
          frame.stop_ok   = tx;
          frame_vld       = 1'b1;
          // second byte of a read, answer unless addr_hi bit 1 is set
          if (second && hi_byte[7] && !hi_byte[1]) begin
            ans_byte    = d ^ 8'h5a;
            ans_bad_par = hi_byte[0];
            req_cnt++;
          end
          if (!second) begin
            hi_byte = d;
          end
          second = !second;
        end
      end
    end
  end

  // response frames on rx, two bit periods after the request
  initial begin : responder
    logic [10:0] bits;
    rx      = 1'b1;
    ans_cnt = 0;
    forever begin
      @(posedge clk);
      if (ans_cnt != req_cnt) begin
        ans_cnt++;
        bits = {1'b1, (~^ans_byte) ^ ans_bad_par, ans_byte, 1'b0};
        repeat (2 * clks_per_bit) @(posedge clk);
        for (int i = 0; i < 11; i++) begin
          rx <= bits[i];
          repeat (clks_per_bit) @(posedge clk);
        end
      end
    end
  end

endmodule

// ==== testbench/tb_uart_cmd_bridge.sv ====
`timescale 1ns/1ps
`include "uart_macros.svh"

module tb_uart_cmd_bridge;

  import uart_frame_pkg::*;
  import cmd_pkg::*;

  localparam int clks_per_bit = 16;
  localparam int num_random   = 12;
  // a read that times out is the longest command
  localparam int wait_limit = (24 + `UART_RESP_TIMEOUT_BITS) * clks_per_bit;

  logic         clk;
  logic         rst_n;
  cmd_word_t    cmd_in;
  logic         cmd_vld;
  logic         cmd_rdy;
  logic         rx;
  logic         tx;
  logic         read_rdy;
  read_result_s read_data;
  logic         frame_vld;
  rx_byte_s     frame;

  cmd_fields_s  cur_cmd;
  logic [1:0]   frames_seen;
  uart_byte_t   exp_byte;
  read_result_s exp_result;
  int           seed;

  tb_clk_gen #(
    .period_ns(10.0)
  ) i_tb_clk_gen (
    .clk(clk)
  );

  uart_cmd_bridge #(
    .clks_per_bit(clks_per_bit)
  ) i_uart_cmd_bridge (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .rx       (rx),
    .tx       (tx),
    .read_rdy (read_rdy),
    .read_data(read_data)
  );

  tb_serial_peer #(
    .clks_per_bit(clks_per_bit)
  ) i_tb_serial_peer (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx       (tx),
    .rx       (rx),
    .frame_vld(frame_vld),
    .frame    (frame)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  function automatic read_result_s expected_read(input cmd_fields_s c);
    read_result_s r;
    // bit 1 of addr_hi means no answer, bit 0 means bad parity
    r.timeout    = c.addr_hi[1];
    r.parity_err = !c.addr_hi[1] && c.addr_hi[0];
    r.data       = c.addr_hi[1] ? 8'h00 : c.addr_lo ^ 8'h5a;
    return r;
  endfunction

  assign exp_byte   = (frames_seen == 2'd0) ? {cur_cmd.rd, cur_cmd.addr_hi} : cur_cmd.addr_lo;
  assign exp_result = expected_read(cur_cmd);

  // copy of the accepted command and its frame count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cur_cmd     <= '0;
      frames_seen <= '0;
    end else if (cmd_vld && cmd_rdy) begin
      cur_cmd     <= cmd_in;
      frames_seen <= '0;
    end else if (frame_vld) begin
      frames_seen <= frames_seen + 1'b1;
    end
  end

  a_frame_bits: assert property (@(posedge clk) disable iff (!rst_n)
    frame_vld |-> frame.parity_ok && frame.stop_ok)
    else fail_run($sformatf("ERROR: frame parity_ok=%h stop_ok=%h, expected 1 and 1",
      $sampled(frame.parity_ok), $sampled(frame.stop_ok)));

  a_frame_count: assert property (@(posedge clk) disable iff (!rst_n)
    frame_vld |-> frames_seen < 2'd2)
    else fail_run("more than two frames were sent for one command");

  a_frame_data: assert property (@(posedge clk) disable iff (!rst_n)
    frame_vld |-> frame.data == exp_byte)
    else fail_run($sformatf("ERROR: frame.data=%h expected %h",
      $sampled(frame.data), $sampled(exp_byte)));

  a_rdy_drop: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_vld && cmd_rdy) |=> !cmd_rdy)
    else fail_run("cmd_rdy stayed high after a command was accepted");

  a_cmd_end: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cmd_rdy) |-> frames_seen == 2'd2 && read_rdy == cur_cmd.rd)
    else fail_run($sformatf("ERROR: at cmd_rdy rise frames_seen=%h read_rdy=%h, expected 2 and %h",
      $sampled(frames_seen), $sampled(read_rdy), $sampled(cur_cmd.rd)));

  a_write_no_read: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |-> cur_cmd.rd)
    else fail_run("read_rdy came for a write command");

  a_read_result: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |-> read_data == exp_result)
    else fail_run($sformatf("ERROR: read_data=%h expected %h",
      $sampled(read_data), $sampled(exp_result)));

  a_read_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else fail_run("read_rdy was high for more than one cycle");

  // line idles high between frames
  a_tx_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_rdy || frames_seen == 2'd2) |-> tx)
    else fail_run($sformatf("ERROR: tx=%h expected 1 while no frame is sent", $sampled(tx)));

  task automatic run_cmd(input cmd_word_t cmd);
    int cnt;
    cmd_in  <= cmd;
    cmd_vld <= 1'b1;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
      if (cnt > wait_limit) begin
        fail_run("command was never accepted");
      end
    end while (!cmd_rdy);
    cmd_vld <= 1'b0;
    // cmd_rdy comes back at the end of the command
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
      if (cnt > wait_limit) begin
        fail_run("command did not finish in time");
      end
    end while (!cmd_rdy);
  endtask

  initial begin : stimulus
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    seed    = 32'h6a462dfc;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    // write, normal read, parity error, no answer
    run_cmd(16'h1234);
    run_cmd(16'h8056);
    run_cmd(16'h81a5);
    run_cmd(16'h8233);
    for (int i = 0; i < num_random; i++) begin
      run_cmd(cmd_word_t'($random(seed)));
    end
    repeat (4) @(posedge clk);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+source
source/uart_frame_pkg.sv
source/cmd_pkg.sv
source/uart_tx_frame.sv
source/uart_rx_frame.sv
source/cmd_sequencer.sv
source/uart_cmd_bridge.sv
testbench/tb_clk_gen.sv
testbench/tb_serial_peer.sv
testbench/tb_uart_cmd_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal -f filelist.f \
       --top-module tb_uart_cmd_bridge \
  && ./obj_dir/Vtb_uart_cmd_bridge | tee /dev/stderr | grep -q "RESULT: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
